// File: cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    localparam int XLEN          = 32;
    localparam int CSR_ADDR_BITS = 12;
    localparam int NUM_IRQ       = 4;
    localparam int IRQ_ID_BITS   = (NUM_IRQ > 1) ? $clog2(NUM_IRQ) : 1;

    // machine-mode csr addresses
    localparam logic [CSR_ADDR_BITS-1:0] MSTATUS_ADDR   = 12'h300;
    localparam logic [CSR_ADDR_BITS-1:0] MIE_ADDR       = 12'h304;
    localparam logic [CSR_ADDR_BITS-1:0] MTVEC_ADDR     = 12'h305;
    localparam logic [CSR_ADDR_BITS-1:0] MEPC_ADDR      = 12'h341;
    localparam logic [CSR_ADDR_BITS-1:0] MIP_ADDR       = 12'h344;
    localparam logic [CSR_ADDR_BITS-1:0] MCYCLE_ADDR    = 12'hB00;
    localparam logic [CSR_ADDR_BITS-1:0] MINSTRET_ADDR  = 12'hB02;
    localparam logic [CSR_ADDR_BITS-1:0] MCYCLEH_ADDR   = 12'hB80;
    localparam logic [CSR_ADDR_BITS-1:0] MINSTRETH_ADDR = 12'hB82;

    // field positions
    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam int MSTATUS_MPP_LSB  = 11;
    localparam int MEIE_BIT         = 11;
    localparam int MEIP_BIT         = 11;

    // writable bits per register
    localparam logic [XLEN-1:0] MSTATUS_WMASK = (XLEN'(1) << MSTATUS_MIE_BIT)
                                              | (XLEN'(1) << MSTATUS_MPIE_BIT)
                                              | (XLEN'(3) << MSTATUS_MPP_LSB);
    localparam logic [XLEN-1:0] MIE_WMASK     = XLEN'(1) << MEIE_BIT;
    localparam logic [XLEN-1:0] MEPC_WMASK    = 32'hFFFF_FFFC;

    localparam logic [XLEN-1:0] MTVEC_RESET = 32'h0000_1000;

    // instruction encodings
    localparam logic [6:0]  OPC_SYSTEM   = 7'b1110011;
    localparam logic [2:0]  F3_PRIV      = 3'b000;
    localparam logic [1:0]  F3_RW        = 2'b01;
    localparam logic [1:0]  F3_RS        = 2'b10;
    localparam logic [1:0]  F3_RC        = 2'b11;
    localparam int          F3_IMM_BIT   = 2;
    localparam logic [11:0] FUNCT12_WFI  = 12'h105;
    localparam logic [11:0] FUNCT12_MRET = 12'h302;

    typedef enum logic [1:0] {
        CSR_NONE  = 2'd0,
        CSR_WRITE = 2'd1,
        CSR_SET   = 2'd2,
        CSR_CLEAR = 2'd3
    } csr_op_e;

    typedef struct packed {
        logic                     valid;
        csr_op_e                  op;
        logic [CSR_ADDR_BITS-1:0] addr;
        logic [XLEN-1:0]          src;
        logic                     wfi;
        logic                     mret;
        logic [XLEN-1:0]          pc;
    } csr_req_t;

endpackage

`default_nettype wire

// File: csr_decode.sv
`timescale 1ns/10ps
`default_nettype none

module csr_decode
    import cpu_pkg::*;
(
    input  logic            instr_valid_i,
    input  logic [XLEN-1:0] instr_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic [XLEN-1:0] rs1_rdata_i,
    output csr_req_t        req_o
);

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [4:0]  rs1_imm;
    logic [11:0] funct12;
    logic        is_system;
    logic        is_priv;

    assign opcode  = instr_i[6:0];
    assign funct3  = instr_i[14:12];
    assign rs1_imm = instr_i[19:15];
    assign funct12 = instr_i[31:20];

    assign is_system = (opcode == OPC_SYSTEM);
    assign is_priv   = is_system && (funct3 == F3_PRIV);

    always_comb begin
        req_o       = '0;
        req_o.valid = instr_valid_i;
        req_o.pc    = pc_i;
        req_o.addr  = funct12;

        // immediate forms carry a zero-extended uimm in the rs1 field
        if (funct3[F3_IMM_BIT]) begin
            req_o.src = {{(XLEN-5){1'b0}}, rs1_imm};
        end else begin
            req_o.src = rs1_rdata_i;
        end

        if (is_system && !is_priv) begin
            case (funct3[1:0])
                F3_RW:   req_o.op = CSR_WRITE;
                F3_RS:   req_o.op = CSR_SET;
                F3_RC:   req_o.op = CSR_CLEAR;
                default: req_o.op = CSR_NONE;
            endcase
        end else begin
            req_o.op = CSR_NONE;
        end

        req_o.wfi  = is_priv && (funct12 == FUNCT12_WFI);
        req_o.mret = is_priv && (funct12 == FUNCT12_MRET);
    end

endmodule

`default_nettype wire

// File: ext_int_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module ext_int_ctrl
    import cpu_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic [NUM_IRQ-1:0]     irq_i,
    input  logic                   int_ack_i,
    output logic                   int_taken_o,
    output logic [IRQ_ID_BITS-1:0] int_id_o
);

    logic [NUM_IRQ-1:0] pending_q;
    logic [NUM_IRQ-1:0] pending_d;

    // lowest pending index wins
    always_comb begin
        int_id_o = '0;
        for (int i = NUM_IRQ - 1; i >= 0; i--) begin
            if (pending_q[i]) begin
                int_id_o = IRQ_ID_BITS'(i);
            end
        end
    end

    assign int_taken_o = |pending_q;

    always_comb begin
        pending_d = pending_q | irq_i;
        // a line still held high stays pending through the ack
        if (int_ack_i) begin
            pending_d[int_id_o] = irq_i[int_id_o];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pending_q <= '0;
        end else begin
            pending_q <= pending_d;
        end
    end

endmodule

`default_nettype wire

// File: csr_file.sv
`timescale 1ns/10ps
`default_nettype none

module csr_file
    import cpu_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  csr_req_t               req_i,
    input  logic                   int_taken_i,
    input  logic [IRQ_ID_BITS-1:0] int_id_i,
    output logic [XLEN-1:0]        rd_wdata_o,
    output logic [XLEN-1:0]        trap_pc_o,
    output logic [XLEN-1:0]        ret_pc_o,
    output logic                   wfi_o,
    output logic                   mret_o,
    output logic                   int_o,
    output logic                   int_ack_o,
    output logic                   stall_o
);

    logic [XLEN-1:0] mstatus_q;
    logic [XLEN-1:0] mie_q;
    logic [XLEN-1:0] mepc_q;
    logic [XLEN-1:0] mip_q;
    logic [63:0]     mcycle_q;
    logic [63:0]     minstret_q;

    logic [IRQ_ID_BITS-1:0] last_int_id_q;

    logic [XLEN-1:0] csr_wdata;
    logic            accept;
    logic            csr_we;
    logic            st_mie;
    logic            meie;
    logic            meip;

    assign accept = req_i.valid & ~stall_o;
    assign csr_we = accept & (req_i.op != CSR_NONE);

    assign st_mie = mstatus_q[MSTATUS_MIE_BIT];
    assign meie   = mie_q[MEIE_BIT];
    assign meip   = mip_q[MEIP_BIT];

    always_comb begin
        case (req_i.addr)
            MSTATUS_ADDR:   rd_wdata_o = mstatus_q;
            MIE_ADDR:       rd_wdata_o = mie_q;
            MTVEC_ADDR:     rd_wdata_o = MTVEC_RESET;
            MEPC_ADDR:      rd_wdata_o = mepc_q;
            MIP_ADDR:       rd_wdata_o = mip_q;
            MCYCLE_ADDR:    rd_wdata_o = mcycle_q[31:0];
            MINSTRET_ADDR:  rd_wdata_o = minstret_q[31:0];
            MCYCLEH_ADDR:   rd_wdata_o = mcycle_q[63:32];
            MINSTRETH_ADDR: rd_wdata_o = minstret_q[63:32];
            default:        rd_wdata_o = '0;
        endcase
    end

    // set/clear work on the current value, so a zero src changes nothing
    always_comb begin
        case (req_i.op)
            CSR_WRITE: csr_wdata = req_i.src;
            CSR_SET:   csr_wdata = rd_wdata_o | req_i.src;
            CSR_CLEAR: csr_wdata = rd_wdata_o & ~req_i.src;
            default:   csr_wdata = rd_wdata_o;
        endcase
    end

    assign trap_pc_o = {MTVEC_RESET[XLEN-1:2], 2'b00};
    assign ret_pc_o  = mepc_q;
    assign wfi_o     = req_i.wfi & meie;
    assign mret_o    = req_i.mret;
    assign int_o     = int_taken_i & st_mie & meip & meie;

    // wfi outranks interrupt entry in the same cycle
    assign int_ack_o = accept & ~req_i.wfi & int_o;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mstatus_q <= '0;
            mie_q     <= '0;
            mepc_q    <= '0;
            mip_q     <= '0;
        end else if (accept && req_i.wfi) begin
            mepc_q          <= req_i.pc + XLEN'(4);
            mip_q[MEIP_BIT] <= meip | meie;
        end else if (accept && int_o) begin
            mstatus_q[MSTATUS_MPP_LSB +: 2] <= 2'b11;
            mstatus_q[MSTATUS_MPIE_BIT]     <= st_mie;
            mstatus_q[MSTATUS_MIE_BIT]      <= 1'b0;
            mip_q[MEIP_BIT]                 <= 1'b0;
        end else if (accept && req_i.mret) begin
            mstatus_q[MSTATUS_MIE_BIT]      <= mstatus_q[MSTATUS_MPIE_BIT];
            mstatus_q[MSTATUS_MPIE_BIT]     <= 1'b1;
            mstatus_q[MSTATUS_MPP_LSB +: 2] <= 2'b11;
        end else if (csr_we) begin
            case (req_i.addr)
                MSTATUS_ADDR: begin
                    mstatus_q <= (mstatus_q & ~MSTATUS_WMASK) | (csr_wdata & MSTATUS_WMASK);
                end
                MIE_ADDR: begin
                    mie_q <= (mie_q & ~MIE_WMASK) | (csr_wdata & MIE_WMASK);
                end
                MEPC_ADDR: begin
                    mepc_q <= (mepc_q & ~MEPC_WMASK) | (csr_wdata & MEPC_WMASK);
                end
                // mtvec, mip and the counters are read-only here
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stall_o <= 1'b0;
        end else if (int_o) begin
            stall_o <= 1'b0;
        end else if (accept && wfi_o) begin
            stall_o <= 1'b1;
        end
    end

    // id of the most recent committed interrupt
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_int_id_q <= '0;
        end else if (int_ack_o) begin
            last_int_id_q <= int_id_i;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mcycle_q   <= '0;
            minstret_q <= '0;
        end else begin
            mcycle_q <= mcycle_q + 64'd1;
            if (accept) begin
                minstret_q <= minstret_q + 64'd1;
            end
        end
    end

endmodule

`default_nettype wire

// File: csr_sys_top.sv
`timescale 1ns/10ps
`default_nettype none

module csr_sys_top
    import cpu_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   instr_valid_i,
    input  logic [XLEN-1:0]        instr_i,
    input  logic [XLEN-1:0]        pc_i,
    input  logic [XLEN-1:0]        rs1_rdata_i,
    input  logic [NUM_IRQ-1:0]     irq_i,
    output logic [XLEN-1:0]        rd_wdata_o,
    output logic [XLEN-1:0]        trap_pc_o,
    output logic [XLEN-1:0]        ret_pc_o,
    output logic                   wfi_o,
    output logic                   mret_o,
    output logic                   int_o,
    output logic                   stall_o,
    output logic [IRQ_ID_BITS-1:0] int_id_o
);

    csr_req_t csr_req;
    logic     int_taken;
    logic     int_ack;

    csr_decode u_csr_decode (
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .pc_i          (pc_i),
        .rs1_rdata_i   (rs1_rdata_i),
        .req_o         (csr_req)
    );

    ext_int_ctrl u_ext_int_ctrl (
        .clk         (clk),
        .rst         (rst),
        .irq_i       (irq_i),
        .int_ack_i   (int_ack),
        .int_taken_o (int_taken),
        .int_id_o    (int_id_o)
    );

    csr_file u_csr_file (
        .clk         (clk),
        .rst         (rst),
        .req_i       (csr_req),
        .int_taken_i (int_taken),
        .int_id_i    (int_id_o),
        .rd_wdata_o  (rd_wdata_o),
        .trap_pc_o   (trap_pc_o),
        .ret_pc_o    (ret_pc_o),
        .wfi_o       (wfi_o),
        .mret_o      (mret_o),
        .int_o       (int_o),
        .int_ack_o   (int_ack),
        .stall_o     (stall_o)
    );

endmodule

`default_nettype wire

// File: csr_sys_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module csr_sys_asserts
    import cpu_pkg::*;
(
    input logic                   clk,
    input logic                   rst,
    input csr_req_t               req_i,
    input logic                   wfi_o,
    input logic                   mret_o,
    input logic                   int_o,
    input logic                   int_ack_o,
    input logic                   stall_o,
    input logic                   int_taken_i,
    input logic [IRQ_ID_BITS-1:0] int_id_i,
    input logic [IRQ_ID_BITS-1:0] last_int_id
);

    // stall only follows an accepted wfi with meie set
    assert property (@(posedge clk) disable iff (rst)
        $rose(stall_o) |-> $past(req_i.valid && wfi_o))
        else $error("stall_o rose without an accepted WFI that had MEIE set");

    assert property (@(posedge clk) disable iff (rst)
        int_ack_o |=> !int_ack_o)
        else $error("int_ack_o stayed high for more than one cycle");

    // the taken line is no longer reported once entry commits
    assert property (@(posedge clk) disable iff (rst)
        int_ack_o |=> !(int_taken_i && int_id_i == last_int_id))
        else $error("acknowledged interrupt id still reported after entry");

    assert property (@(posedge clk)
        $fell(rst) |-> !stall_o && !int_o && !int_ack_o && !wfi_o && !mret_o)
        else $error("control outputs not low after reset");

endmodule

bind csr_file csr_sys_asserts u_csr_sys_asserts (
    .clk         (clk),
    .rst         (rst),
    .req_i       (req_i),
    .wfi_o       (wfi_o),
    .mret_o      (mret_o),
    .int_o       (int_o),
    .int_ack_o   (int_ack_o),
    .stall_o     (stall_o),
    .int_taken_i (int_taken_i),
    .int_id_i    (int_id_i),
    .last_int_id (last_int_id_q)
);

`default_nettype wire

// File: tb_csr_sys.sv
`timescale 1ns/10ps
`default_nettype none

module tb_csr_sys
    import cpu_pkg::*;
();

    localparam int          TIMEOUT_CYCLES = 2000;
    localparam logic [31:0] NOP_INSTR      = 32'h0000_0013;
    localparam logic [31:0] WFI_INSTR      = 32'h1050_0073;
    localparam logic [31:0] MRET_INSTR     = 32'h3020_0073;

    logic                   clk;
    logic                   rst;
    logic                   instr_valid_i;
    logic [XLEN-1:0]        instr_i;
    logic [XLEN-1:0]        pc_i;
    logic [XLEN-1:0]        rs1_rdata_i;
    logic [NUM_IRQ-1:0]     irq_i;
    logic [XLEN-1:0]        rd_wdata_o;
    logic [XLEN-1:0]        trap_pc_o;
    logic [XLEN-1:0]        ret_pc_o;
    logic                   wfi_o;
    logic                   mret_o;
    logic                   int_o;
    logic                   stall_o;
    logic [IRQ_ID_BITS-1:0] int_id_o;

    // reference copies of the csrs
    logic [31:0] mstatus_m;
    logic [31:0] mie_m;
    logic [31:0] mepc_m;
    logic [31:0] mip_m;
    int          cycle_cnt = 0;
    int          issued = 0;
    int          seed;

    csr_sys_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // whole sequence runs in roughly 130 cycles
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", cycle_cnt);
            $display("Regression failed");
            $fatal(1);
        end
    end

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
            $display("Regression failed");
            $fatal(1);
        end
    endtask

    function automatic logic [31:0] model_read(input logic [11:0] addr);
        case (addr)
            MSTATUS_ADDR: model_read = mstatus_m;
            MIE_ADDR:     model_read = mie_m;
            MTVEC_ADDR:   model_read = 32'h0000_1000;
            MEPC_ADDR:    model_read = mepc_m;
            MIP_ADDR:     model_read = mip_m;
            default:      model_read = 32'h0;
        endcase
    endfunction

    task automatic issue_instr(input logic [31:0] instr, input logic [31:0] pc,
                               input logic [31:0] rs1);
        @(posedge clk);
        instr_valid_i <= 1'b1;
        instr_i       <= instr;
        pc_i          <= pc;
        rs1_rdata_i   <= rs1;
        issued = issued + 1;
        @(negedge clk);
    endtask

    // csrrs with a zero source only reads
    task automatic read_csr(input logic [11:0] addr, output logic [31:0] val);
        issue_instr({addr, 5'd0, 3'b010, 5'd1, 7'b1110011}, 32'h0, 32'h0);
        val = rd_wdata_o;
    endtask

    task automatic run_csr_op(input logic [2:0] f3, input logic [11:0] addr,
                              input logic [31:0] operand);
        logic [31:0] src;
        logic [31:0] old;
        logic [31:0] nv;
        logic [31:0] v;
        src = f3[2] ? {27'd0, operand[4:0]} : operand;
        old = model_read(addr);
        issue_instr({addr, operand[4:0], f3, 5'd1, 7'b1110011}, 32'h0, operand);
        check_value("rd_wdata_o", rd_wdata_o, old);
        case (f3[1:0])
            2'b01:   nv = src;
            2'b10:   nv = old | src;
            default: nv = old & ~src;
        endcase
        // mstatus keeps MIE, MPIE and MPP; mie keeps MEIE; mepc keeps 31:2
        case (addr)
            MSTATUS_ADDR: mstatus_m = (old & ~32'h1888) | (nv & 32'h1888);
            MIE_ADDR:     mie_m = (old & ~32'h800) | (nv & 32'h800);
            MEPC_ADDR:    mepc_m = (old & 32'h3) | (nv & 32'hFFFF_FFFC);
            default: ;
        endcase
        read_csr(addr, v);
        check_value($sformatf("csr 0x%03h", addr), v, model_read(addr));
    endtask

    task automatic check_reset_values();
        logic [11:0] addrs [9];
        logic [31:0] v;
        addrs = '{MINSTRET_ADDR, MINSTRETH_ADDR, MCYCLEH_ADDR, MSTATUS_ADDR,
                  MIE_ADDR, MTVEC_ADDR, MEPC_ADDR, MIP_ADDR, 12'h7C0};
        @(negedge clk);
        check_value("control outputs", {28'd0, stall_o, int_o, wfi_o, mret_o}, 32'h0);
        check_value("trap_pc_o", trap_pc_o, 32'h0000_1000);
        foreach (addrs[i]) begin
            read_csr(addrs[i], v);
            check_value($sformatf("csr 0x%03h", addrs[i]), v, model_read(addrs[i]));
        end
    endtask

    task automatic exercise_csr_ops();
        logic [11:0] regs [4];
        logic [2:0]  ops [6];
        regs = '{MSTATUS_ADDR, MIE_ADDR, MEPC_ADDR, MTVEC_ADDR};
        ops  = '{3'b001, 3'b010, 3'b011, 3'b101, 3'b110, 3'b111};
        foreach (regs[r]) begin
            foreach (ops[o]) begin
                run_csr_op(ops[o], regs[r], $urandom);
            end
            run_csr_op(3'b010, regs[r], 32'h0);
            run_csr_op(3'b111, regs[r], 32'h0);
        end
    endtask

    task automatic measure_counters();
        logic [31:0] i0;
        logic [31:0] i1;
        logic [31:0] c0;
        logic [31:0] c1;
        int          n0;
        int          k0;
        read_csr(MINSTRET_ADDR, i0);
        k0 = issued;
        read_csr(MCYCLE_ADDR, c0);
        n0 = cycle_cnt;
        repeat (4) issue_instr(NOP_INSTR, 32'h0, 32'h0);
        @(posedge clk);
        instr_valid_i <= 1'b0;
        repeat (2) @(posedge clk);
        repeat (2) issue_instr(NOP_INSTR, 32'h0, 32'h0);
        read_csr(MCYCLE_ADDR, c1);
        check_value("mcycle delta", c1 - c0, 32'(cycle_cnt - n0));
        read_csr(MINSTRET_ADDR, i1);
        check_value("minstret delta", i1 - i0, 32'(issued - k0));
    endtask

    task automatic take_interrupt(input logic [31:0] pc, input logic [NUM_IRQ-1:0] lines,
                                  input logic [31:0] exp_id);
        logic [31:0] old_mie;
        logic [31:0] v;
        old_mie = (mstatus_m >> MSTATUS_MIE_BIT) & 32'h1;
        issue_instr(WFI_INSTR, pc, 32'h0);
        check_value("wfi_o", 32'(wfi_o), 32'h1);
        mepc_m = pc + 32'h4;
        mip_m  = mip_m | (32'h1 << MEIP_BIT);
        // next instruction is held behind the stall
        @(posedge clk);
        instr_i <= NOP_INSTR;
        irq_i   <= lines;
        @(negedge clk);
        check_value("stall_o", 32'(stall_o), 32'h1);
        check_value("ret_pc_o", ret_pc_o, mepc_m);
        @(posedge clk);
        irq_i <= '0;
        @(negedge clk);
        while (!int_o) @(negedge clk);
        check_value("int_id_o", 32'(int_id_o), exp_id);
        while (stall_o) @(negedge clk);
        check_value("int_o", 32'(int_o), 32'h1);
        mstatus_m = (mstatus_m & ~32'h1888) | (32'h3 << MSTATUS_MPP_LSB)
                  | (old_mie << MSTATUS_MPIE_BIT);
        mip_m = 32'h0;
        read_csr(MSTATUS_ADDR, v);
        check_value("mstatus", v, mstatus_m);
    endtask

    task automatic mret_restore();
        logic [31:0] mpie;
        logic [31:0] v;
        mpie = (mstatus_m >> MSTATUS_MPIE_BIT) & 32'h1;
        issue_instr(MRET_INSTR, 32'h0000_3000, 32'h0);
        check_value("mret_o", 32'(mret_o), 32'h1);
        mstatus_m = (mstatus_m & ~32'h1888) | (mpie << MSTATUS_MIE_BIT)
                  | (32'h1 << MSTATUS_MPIE_BIT) | (32'h3 << MSTATUS_MPP_LSB);
        read_csr(MSTATUS_ADDR, v);
        check_value("mstatus", v, mstatus_m);
    endtask

    task automatic wfi_without_meie(input logic [31:0] pc);
        logic [31:0] v;
        run_csr_op(3'b011, MIE_ADDR, 32'h800);
        run_csr_op(3'b110, MSTATUS_ADDR, 32'h8);
        issue_instr(WFI_INSTR, pc, 32'h0);
        check_value("wfi_o", 32'(wfi_o), 32'h0);
        mepc_m = pc + 32'h4;
        @(posedge clk);
        instr_valid_i <= 1'b0;
        irq_i         <= NUM_IRQ'(1);
        repeat (4) begin
            @(negedge clk);
            check_value("stall_o/int_o", {30'd0, stall_o, int_o}, 32'h0);
            @(posedge clk);
            irq_i <= '0;
        end
        read_csr(MEPC_ADDR, v);
        check_value("mepc", v, mepc_m);
        // meip stays clear without meie
        read_csr(MIP_ADDR, v);
        check_value("mip", v, mip_m);
    endtask

    initial begin
        seed          = $urandom(26);
        rst           = 1'b1;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        pc_i          = '0;
        rs1_rdata_i   = '0;
        irq_i         = '0;
        mstatus_m     = '0;
        mie_m         = '0;
        mepc_m        = '0;
        mip_m         = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        check_reset_values();
        exercise_csr_ops();
        measure_counters();
        run_csr_op(3'b001, MSTATUS_ADDR, 32'h8);
        run_csr_op(3'b001, MIE_ADDR, 32'h800);
        take_interrupt(32'h0000_2000, NUM_IRQ'(6), 32'd1);
        mret_restore();
        take_interrupt($urandom & 32'h00FF_FFFC, '0, 32'd2);
        wfi_without_meie(32'h0000_4010);
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
cpu_pkg.sv
csr_decode.sv
ext_int_ctrl.sv
csr_file.sv
csr_sys_top.sv
csr_sys_asserts.sv
tb_csr_sys.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the regression, the exit status follows the simulation
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_csr_sys -f list.f -o tb_csr_sys &&
./obj_dir/tb_csr_sys || exit 1
